// File: all.f
src/glb_io_pkg.sv
src/stream_if.sv
src/stream_sequencer.sv
src/bank_access.sv
src/read_return.sv
src/glb_io_addr_gen.sv
sim/glb_io_addr_gen_props.sv
sim/glb_io_addr_gen_tb.sv

// File: sim/glb_io_addr_gen_tb.sv
// Address generator testbench
`default_nettype none
`timescale 1ns/10ps

module glb_io_addr_gen_tb;

    localparam int NUM_RUNS = 9;
    localparam int LAT      = glb_io_pkg::BANK_READ_LATENCY;
    localparam int W        = glb_io_pkg::CGRA_DATA_WIDTH;

    typedef struct packed {
        glb_io_pkg::stream_mode_t mode;
        glb_io_pkg::glb_addr_t    start;
        glb_io_pkg::glb_addr_t    words;
        glb_io_pkg::done_delay_t  delay;
        logic                     gaps;
    } run_t;

    logic                     clk = 1'b0;
    logic                     reset;
    glb_io_pkg::stream_mode_t mode;
    logic                     cgra_start_pulse;
    glb_io_pkg::glb_addr_t    start_addr;
    glb_io_pkg::glb_addr_t    num_words;
    glb_io_pkg::done_delay_t  done_delay;
    logic                     cgra_done_pulse;
    logic                     cgra_wr_en;
    glb_io_pkg::cgra_data_t   cgra_wr_data;
    glb_io_pkg::cgra_data_t   cgra_rd_data;
    logic                     cgra_rd_data_valid;
    logic                     bank_rd_en;
    logic                     bank_wr_en;
    glb_io_pkg::bank_data_t   bank_wr_data;
    glb_io_pkg::bank_data_t   bank_bit_sel;
    glb_io_pkg::glb_addr_t    bank_addr;
    glb_io_pkg::bank_data_t   bank_rd_data;
    logic                     bank_rd_data_valid;

    run_t                     runs [NUM_RUNS];
    logic [31:0]              lcg_state = 32'hd5cd;
    int                       cyc = 0;
    int                       start_cyc;
    int                       last_valid_cyc;

    // Port activity seen during the current run
    int                       acc_cyc [$];
    glb_io_pkg::cgra_data_t   acc_data [$];
    glb_io_pkg::cgra_data_t   rd_q [$];
    glb_io_pkg::glb_addr_t    rd_addr_q [$];
    glb_io_pkg::glb_addr_t    wr_addr_q [$];
    glb_io_pkg::bank_data_t   wr_data_q [$];
    glb_io_pkg::bank_data_t   wr_sel_q [$];
    int                       done_q [$];

    logic [LAT-1:0]           rd_pipe = '0;
    glb_io_pkg::glb_addr_t    addr_pipe [LAT] = '{default: '0};

    glb_io_addr_gen glb_io_addr_gen_i (
        .clk                (clk),
        .reset              (reset),
        .mode               (mode),
        .cgra_start_pulse   (cgra_start_pulse),
        .start_addr         (start_addr),
        .num_words          (num_words),
        .done_delay         (done_delay),
        .cgra_done_pulse    (cgra_done_pulse),
        .cgra_wr_en         (cgra_wr_en),
        .cgra_wr_data       (cgra_wr_data),
        .cgra_rd_data       (cgra_rd_data),
        .cgra_rd_data_valid (cgra_rd_data_valid),
        .bank_rd_en         (bank_rd_en),
        .bank_wr_en         (bank_wr_en),
        .bank_wr_data       (bank_wr_data),
        .bank_bit_sel       (bank_bit_sel),
        .bank_addr          (bank_addr),
        .bank_rd_data       (bank_rd_data),
        .bank_rd_data_valid (bank_rd_data_valid)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic glb_io_pkg::bank_data_t bank_word(input glb_io_pkg::glb_addr_t a);
        return {a, a ^ 16'ha5a5, a, a ^ 16'ha5a5};
    endfunction

    function automatic glb_io_pkg::glb_addr_t aligned(input glb_io_pkg::glb_addr_t a);
        return (a >> glb_io_pkg::BANK_ADDR_OFFSET) << glb_io_pkg::BANK_ADDR_OFFSET;
    endfunction

    // Fabric word expected at a byte address
    function automatic glb_io_pkg::cgra_data_t lane_word(input glb_io_pkg::glb_addr_t a);
        glb_io_pkg::bank_data_t bw;
        bw = bank_word(aligned(a));
        return bw[a[2:1]*W +: W];
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Bank model answers each read after the fixed latency
    always @(posedge clk) begin
        rd_pipe[0] <= bank_rd_en;
        if (bank_rd_en) begin
            addr_pipe[0] <= bank_addr;
        end
        for (int i = 1; i < LAT; i++) begin
            rd_pipe[i]   <= rd_pipe[i-1];
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    assign bank_rd_data_valid = rd_pipe[LAT-1];
    assign bank_rd_data       = bank_word(addr_pipe[LAT-1]);

    // Record port activity mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (cgra_start_pulse) begin
                start_cyc = cyc;
            end
            if (cgra_wr_en) begin
                acc_cyc.push_back(cyc);
                acc_data.push_back(cgra_wr_data);
            end
            if (cgra_rd_data_valid) begin
                rd_q.push_back(cgra_rd_data);
                last_valid_cyc = cyc;
            end
            if (bank_rd_en) begin
                rd_addr_q.push_back(bank_addr);
            end
            if (bank_wr_en) begin
                wr_addr_q.push_back(bank_addr);
                wr_data_q.push_back(bank_wr_data);
                wr_sel_q.push_back(bank_bit_sel);
            end
            if (cgra_done_pulse) begin
                done_q.push_back(cyc);
            end
        end
    end

    task automatic report_failure();
        $display("tests failed");
        $fatal(1, "stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
            report_failure();
        end
    endtask

    task automatic load_runs();
        runs[0] = '{glb_io_pkg::IDLE,      16'h0040, 16'd8,  8'd4, 1'b0};
        runs[1] = '{glb_io_pkg::INSTREAM,  16'h0106, 16'd11, 8'd3, 1'b0};
        runs[2] = '{glb_io_pkg::INSTREAM,  16'h0200, 16'd8,  8'd5, 1'b0};
        runs[3] = '{glb_io_pkg::OUTSTREAM, 16'h0302, 16'd13, 8'd0, 1'b1};
        runs[4] = '{glb_io_pkg::OUTSTREAM, 16'h0400, 16'd8,  8'd2, 1'b0};
        runs[5] = '{glb_io_pkg::INSTREAM,  16'h0510, 16'd0,  8'd6, 1'b0};
        runs[6] = '{glb_io_pkg::OUTSTREAM, 16'h0604, 16'd0,  8'd1, 1'b0};
        runs[7] = '{glb_io_pkg::OUTSTREAM, 16'h07fa, 16'd9,  8'd7, 1'b1};
        runs[8] = '{glb_io_pkg::INSTREAM,  16'h0802, 16'd1,  8'd3, 1'b0};
    endtask

    task automatic clear_events();
        acc_cyc.delete();
        acc_data.delete();
        rd_q.delete();
        rd_addr_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_sel_q.delete();
        done_q.delete();
    endtask

    task automatic apply_run(input run_t r);
        int          sent;
        logic [31:0] rnd;
        @(posedge clk);
        mode       <= r.mode;
        start_addr <= r.start;
        num_words  <= r.words;
        done_delay <= r.delay;
        repeat (2) @(posedge clk);
        clear_events();
        cgra_start_pulse <= 1'b1;
        // Fabric writes in IDLE must be ignored as well
        if (r.mode == glb_io_pkg::IDLE) begin
            cgra_wr_en <= 1'b1;
        end
        @(posedge clk);
        cgra_start_pulse <= 1'b0;
        if (r.mode == glb_io_pkg::OUTSTREAM) begin
            sent = 0;
            while (sent < r.words) begin
                rnd = lcg_next();
                // At most one idle cycle before each word
                if (r.gaps && rnd[20]) begin
                    cgra_wr_en <= 1'b0;
                    @(posedge clk);
                end
                cgra_wr_en   <= 1'b1;
                cgra_wr_data <= rnd[31:16];
                sent++;
                @(posedge clk);
            end
        end
        cgra_wr_en <= 1'b0;
    endtask

    task automatic wait_for_done(input int limit);
        int waited;
        waited = 0;
        while (done_q.size() == 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (done_q.size() == 0) begin
            $display("no done pulse within %0d cycles of the start", limit);
            report_failure();
        end
        // Let trailing traffic drain and catch a repeated pulse
        repeat (4) @(posedge clk);
    endtask

    task automatic check_run(input run_t r);
        glb_io_pkg::glb_addr_t  exp_rd_addr [$];
        glb_io_pkg::glb_addr_t  exp_wr_addr [$];
        glb_io_pkg::bank_data_t exp_wr_data [$];
        glb_io_pkg::bank_data_t exp_wr_sel [$];
        glb_io_pkg::bank_data_t pend_data;
        glb_io_pkg::bank_data_t pend_sel;
        glb_io_pkg::glb_addr_t  a;
        int                     n;
        int                     last_step;
        n = r.words;
        if (r.mode == glb_io_pkg::OUTSTREAM) begin
            last_step = (n == 0) ? start_cyc : acc_cyc[n-1];
        end else begin
            last_step = start_cyc + n;
        end
        if (r.mode == glb_io_pkg::IDLE) begin
            check_value("cgra_done_pulse count", done_q.size(), 0);
            n = 0;
        end else begin
            check_value("cgra_done_pulse count", done_q.size(), 1);
            check_value("cgra_done_pulse cycle", done_q[0], last_step + r.delay + 1);
        end
        // Expected bank traffic from the lane rules
        pend_data = '0;
        pend_sel  = '0;
        for (int k = 0; k < n; k++) begin
            a = r.start + glb_io_pkg::glb_addr_t'(glb_io_pkg::CGRA_DATA_BYTES * k);
            if (r.mode == glb_io_pkg::INSTREAM) begin
                if (k == 0 || a[2:1] == 2'd0) begin
                    exp_rd_addr.push_back(aligned(a));
                end
            end else begin
                pend_data[a[2:1]*W +: W] = acc_data[k];
                pend_sel[a[2:1]*W +: W]  = '1;
                if (a[2:1] == 2'd3 || k == n - 1) begin
                    exp_wr_addr.push_back(aligned(a));
                    exp_wr_data.push_back(pend_data);
                    exp_wr_sel.push_back(pend_sel);
                    pend_data = '0;
                    pend_sel  = '0;
                end
            end
        end
        check_value("bank_rd_en count", rd_addr_q.size(), exp_rd_addr.size());
        for (int i = 0; i < exp_rd_addr.size(); i++) begin
            check_value("bank_addr on read", rd_addr_q[i], exp_rd_addr[i]);
        end
        check_value("bank_wr_en count", wr_addr_q.size(), exp_wr_addr.size());
        for (int i = 0; i < exp_wr_addr.size(); i++) begin
            check_value("bank_addr on write", wr_addr_q[i], exp_wr_addr[i]);
            check_value("bank_bit_sel", wr_sel_q[i], exp_wr_sel[i]);
            check_value("bank_wr_data", wr_data_q[i] & exp_wr_sel[i], exp_wr_data[i]);
        end
        if (r.mode == glb_io_pkg::INSTREAM) begin
            check_value("cgra_rd_data_valid count", rd_q.size(), n);
            for (int k = 0; k < n; k++) begin
                a = r.start + glb_io_pkg::glb_addr_t'(glb_io_pkg::CGRA_DATA_BYTES * k);
                check_value("cgra_rd_data", rd_q[k], lane_word(a));
            end
            if (n > 0) begin
                check_value("done after last word", done_q[0] > last_valid_cyc, 1);
            end
        end else begin
            check_value("cgra_rd_data_valid count", rd_q.size(), 0);
        end
    endtask

    initial begin
        reset            = 1'b1;
        mode             = glb_io_pkg::IDLE;
        cgra_start_pulse = 1'b0;
        start_addr       = '0;
        num_words        = '0;
        done_delay       = '0;
        cgra_wr_en       = 1'b0;
        cgra_wr_data     = '0;
        load_runs();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("cgra_done_pulse", cgra_done_pulse, 0);
        check_value("bank_rd_en", bank_rd_en, 0);
        check_value("bank_wr_en", bank_wr_en, 0);
        check_value("cgra_rd_data_valid", cgra_rd_data_valid, 0);
        for (int i = 0; i < NUM_RUNS; i++) begin
            apply_run(runs[i]);
            if (runs[i].mode == glb_io_pkg::IDLE) begin
                repeat (runs[i].words + runs[i].delay + 8) @(posedge clk);
            end else begin
                wait_for_done(2 * runs[i].words + runs[i].delay + 20);
            end
            check_run(runs[i]);
        end
        $display("all tests passed");
        $finish;
    end

    // Watchdog sized from the run table
    initial begin
        int limit;
        #1;
        limit = 24;
        for (int i = 0; i < NUM_RUNS; i++) begin
            limit += 2 * runs[i].words + runs[i].delay + 20;
        end
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles before the runs finished", limit);
        report_failure();
    end

endmodule

`default_nettype wire

// File: sim/glb_io_addr_gen_props.sv
// Address generator port properties
`default_nettype none
`timescale 1ns/10ps

module glb_io_addr_gen_props (
    input logic                     clk,
    input logic                     reset,
    input glb_io_pkg::stream_mode_t mode,
    input logic                     cgra_done_pulse,
    input logic                     cgra_rd_data_valid,
    input logic                     bank_rd_en,
    input logic                     bank_wr_en,
    input glb_io_pkg::glb_addr_t    bank_addr
);

    // Done is a single-cycle pulse
    done_single: assert property (@(posedge clk) disable iff (reset)
        cgra_done_pulse |=> !cgra_done_pulse)
        else $error("cgra_done_pulse held for two cycles");

    // Reads and writes never share a cycle
    rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(bank_rd_en && bank_wr_en))
        else $error("bank_rd_en and bank_wr_en high together");

    // Bank addresses stay bank-word aligned
    addr_aligned: assert property (@(posedge clk) disable iff (reset)
        (bank_rd_en || bank_wr_en) |->
            (bank_addr[glb_io_pkg::BANK_ADDR_OFFSET-1:0] == '0))
        else $error("bank_addr not aligned while an enable is high");

    no_read_out: assert property (@(posedge clk) disable iff (reset)
        (mode == glb_io_pkg::OUTSTREAM) |-> !cgra_rd_data_valid)
        else $error("cgra_rd_data_valid high in OUTSTREAM");

endmodule

bind glb_io_addr_gen glb_io_addr_gen_props glb_io_addr_gen_props_i (
    .clk                (clk),
    .reset              (reset),
    .mode               (mode),
    .cgra_done_pulse    (cgra_done_pulse),
    .cgra_rd_data_valid (cgra_rd_data_valid),
    .bank_rd_en         (bank_rd_en),
    .bank_wr_en         (bank_wr_en),
    .bank_addr          (bank_addr)
);

`default_nettype wire

// File: src/glb_io_addr_gen.sv
// Global buffer I/O address generator
`default_nettype none
`timescale 1ns/10ps

module glb_io_addr_gen (
    input  logic                     clk,
    input  logic                     reset,

    // Configuration and control
    input  glb_io_pkg::stream_mode_t mode,
    input  logic                     cgra_start_pulse,
    input  glb_io_pkg::glb_addr_t    start_addr,
    input  glb_io_pkg::glb_addr_t    num_words,
    input  glb_io_pkg::done_delay_t  done_delay,
    output logic                     cgra_done_pulse,

    // Fabric side
    input  logic                     cgra_wr_en,
    input  glb_io_pkg::cgra_data_t   cgra_wr_data,
    output glb_io_pkg::cgra_data_t   cgra_rd_data,
    output logic                     cgra_rd_data_valid,

    // Bank side
    output logic                     bank_rd_en,
    output logic                     bank_wr_en,
    output glb_io_pkg::bank_data_t   bank_wr_data,
    output glb_io_pkg::bank_data_t   bank_bit_sel,
    output glb_io_pkg::glb_addr_t    bank_addr,
    input  glb_io_pkg::bank_data_t   bank_rd_data,
    input  logic                     bank_rd_data_valid
);

    logic                  word_issue;
    glb_io_pkg::lane_sel_t word_lane;

    stream_if strm ();

    stream_sequencer stream_sequencer_i (
        .clk              (clk),
        .reset            (reset),
        .mode             (mode),
        .cgra_start_pulse (cgra_start_pulse),
        .start_addr       (start_addr),
        .num_words        (num_words),
        .done_delay       (done_delay),
        .cgra_wr_en       (cgra_wr_en),
        .cgra_done_pulse  (cgra_done_pulse),
        .strm             (strm.seq)
    );

    bank_access bank_access_i (
        .clk          (clk),
        .reset        (reset),
        .strm         (strm.bank),
        .cgra_wr_data (cgra_wr_data),
        .bank_rd_en   (bank_rd_en),
        .bank_wr_en   (bank_wr_en),
        .bank_wr_data (bank_wr_data),
        .bank_bit_sel (bank_bit_sel),
        .bank_addr    (bank_addr),
        .word_issue   (word_issue),
        .word_lane    (word_lane)
    );

    read_return read_return_i (
        .clk                (clk),
        .reset              (reset),
        .word_issue         (word_issue),
        .word_lane          (word_lane),
        .bank_rd_data       (bank_rd_data),
        .bank_rd_data_valid (bank_rd_data_valid),
        .cgra_rd_data       (cgra_rd_data),
        .cgra_rd_data_valid (cgra_rd_data_valid)
    );

endmodule

`default_nettype wire

// File: src/read_return.sv
// Bank read data return
`default_nettype none
`timescale 1ns/10ps

module read_return (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   word_issue,
    input  glb_io_pkg::lane_sel_t  word_lane,
    input  glb_io_pkg::bank_data_t bank_rd_data,
    input  logic                   bank_rd_data_valid,
    output glb_io_pkg::cgra_data_t cgra_rd_data,
    output logic                   cgra_rd_data_valid
);

    localparam int LAT = glb_io_pkg::BANK_READ_LATENCY;

    logic [LAT-1:0]         issue_pipe;
    glb_io_pkg::lane_sel_t  lane_pipe [LAT];
    glb_io_pkg::bank_data_t held_word;
    glb_io_pkg::bank_data_t cur_word;
    glb_io_pkg::lane_sel_t  lane_d;
    logic                   issue_d;
    logic                   take_word;

    // Match the bank latency so each word meets its data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_pipe <= '0;
        end else begin
            issue_pipe[0] <= word_issue;
            for (int i = 1; i < LAT; i++) begin
                issue_pipe[i] <= issue_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        lane_pipe[0] <= word_lane;
        for (int i = 1; i < LAT; i++) begin
            lane_pipe[i] <= lane_pipe[i-1];
        end
    end

    assign issue_d = issue_pipe[LAT-1];
    assign lane_d  = lane_pipe[LAT-1];

    // Fresh bank data arrives only for words that issued a read
    assign take_word = issue_d && bank_rd_data_valid;

    always_ff @(posedge clk) begin
        if (take_word) begin
            held_word <= bank_rd_data;
        end
    end

    // Later lanes of the same bank word come from the held copy
    assign cur_word = take_word ? bank_rd_data : held_word;

    assign cgra_rd_data       = cur_word[lane_d*glb_io_pkg::CGRA_DATA_WIDTH +:
                                         glb_io_pkg::CGRA_DATA_WIDTH];
    assign cgra_rd_data_valid = issue_d;

endmodule

`default_nettype wire

// File: src/bank_access.sv
// Bank read and write issue
`default_nettype none
`timescale 1ns/10ps

module bank_access (
    input  logic                   clk,
    input  logic                   reset,
    stream_if.bank                 strm,
    input  glb_io_pkg::cgra_data_t cgra_wr_data,
    output logic                   bank_rd_en,
    output logic                   bank_wr_en,
    output glb_io_pkg::bank_data_t bank_wr_data,
    output glb_io_pkg::bank_data_t bank_bit_sel,
    output glb_io_pkg::glb_addr_t  bank_addr,
    output logic                   word_issue,
    output glb_io_pkg::lane_sel_t  word_lane
);

    glb_io_pkg::lane_sel_t  lane;
    glb_io_pkg::glb_addr_t  aligned_addr;
    glb_io_pkg::bank_data_t pack_data;
    glb_io_pkg::bank_data_t pack_sel;
    glb_io_pkg::bank_data_t merged_data;
    glb_io_pkg::bank_data_t merged_sel;
    logic                   wr_step;
    logic                   need_read;
    logic                   flush;

    // Lane index sits just above the byte-within-word bit
    assign lane = strm.addr[glb_io_pkg::BANK_ADDR_OFFSET-1 -: glb_io_pkg::LANE_SEL_WIDTH];

    assign aligned_addr = {strm.addr[glb_io_pkg::GLB_ADDR_WIDTH-1:glb_io_pkg::BANK_ADDR_OFFSET],
                           {glb_io_pkg::BANK_ADDR_OFFSET{1'b0}}};

    assign wr_step = strm.step && strm.write;

    // New bank word needed at run start or on a lane 0 crossing
    assign need_read = strm.step && !strm.write && (strm.first || (lane == '0));

    // Write out at the top lane or at the end of the run
    assign flush = wr_step &&
                   (strm.last || (lane == glb_io_pkg::lane_sel_t'(glb_io_pkg::LANES - 1)));

    // Merge this word into the pending bank word
    always_comb begin
        if (strm.first) begin
            merged_data = '0;
            merged_sel  = '0;
        end else begin
            merged_data = pack_data;
            merged_sel  = pack_sel;
        end
        merged_data[lane*glb_io_pkg::CGRA_DATA_WIDTH +: glb_io_pkg::CGRA_DATA_WIDTH] =
            cgra_wr_data;
        merged_sel[lane*glb_io_pkg::CGRA_DATA_WIDTH +: glb_io_pkg::CGRA_DATA_WIDTH] =
            {glb_io_pkg::CGRA_DATA_WIDTH{1'b1}};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_rd_en <= 1'b0;
            bank_wr_en <= 1'b0;
            word_issue <= 1'b0;
            pack_sel   <= '0;
        end else begin
            bank_rd_en <= need_read;
            bank_wr_en <= flush;
            word_issue <= strm.step && !strm.write;
            if (wr_step) begin
                pack_sel <= flush ? '0 : merged_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strm.step) begin
            word_lane <= lane;
        end
        if (need_read || flush) begin
            bank_addr <= aligned_addr;
        end
        if (wr_step) begin
            pack_data <= flush ? '0 : merged_data;
        end
        if (flush) begin
            bank_wr_data <= merged_data;
            bank_bit_sel <= merged_sel;
        end
    end

endmodule

`default_nettype wire

// File: src/stream_sequencer.sv
// Stream word sequencer
`default_nettype none
`timescale 1ns/10ps

module stream_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  glb_io_pkg::stream_mode_t mode,
    input  logic                     cgra_start_pulse,
    input  glb_io_pkg::glb_addr_t    start_addr,
    input  glb_io_pkg::glb_addr_t    num_words,
    input  glb_io_pkg::done_delay_t  done_delay,
    input  logic                     cgra_wr_en,
    output logic                     cgra_done_pulse,
    stream_if.seq                    strm
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } seq_state_t;

    seq_state_t              state;
    glb_io_pkg::glb_addr_t   words_left;
    glb_io_pkg::glb_addr_t   word_addr;
    glb_io_pkg::done_delay_t done_cnt;
    logic                    first_pend;

    logic                    in_mode;
    logic                    out_mode;
    logic                    stream_mode;
    logic                    step;

    assign in_mode     = (mode == glb_io_pkg::INSTREAM);
    assign out_mode    = (mode == glb_io_pkg::OUTSTREAM);
    assign stream_mode = in_mode || out_mode;

    // INSTREAM advances every cycle, OUTSTREAM only on fabric writes
    assign step = (state == RUN) && (in_mode || (out_mode && cgra_wr_en));

    assign strm.step  = step;
    assign strm.write = out_mode;
    assign strm.first = first_pend;
    assign strm.last  = (words_left == glb_io_pkg::glb_addr_t'(1));
    assign strm.addr  = word_addr;

    // Done pulse lands on the cycle the delay count runs out
    assign cgra_done_pulse = (state == DONE) && (done_cnt == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            words_left <= '0;
            word_addr  <= '0;
            done_cnt   <= '0;
            first_pend <= 1'b0;
        end else if (!stream_mode) begin
            state      <= IDLE;
            first_pend <= 1'b0;
        end else if (cgra_start_pulse) begin
            // Load a new run, restarting any run in progress
            word_addr  <= start_addr;
            words_left <= num_words;
            done_cnt   <= done_delay;
            first_pend <= 1'b1;
            if (num_words == '0) begin
                state <= DONE;
            end else begin
                state <= RUN;
            end
        end else begin
            case (state)
                RUN: begin
                    if (step) begin
                        word_addr  <= word_addr +
                                      glb_io_pkg::glb_addr_t'(glb_io_pkg::CGRA_DATA_BYTES);
                        words_left <= words_left - 1'b1;
                        first_pend <= 1'b0;
                        if (strm.last) begin
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    // Count down the programmed delay before the pulse
                    if (done_cnt == '0) begin
                        state <= IDLE;
                    end else begin
                        done_cnt <= done_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/stream_if.sv
// Per-word step channel
`default_nettype none
`timescale 1ns/10ps

interface stream_if;

    // One pulse per accepted word
    logic                  step;

    // High while streaming toward the bank
    logic                  write;

    // Qualifiers valid together with step
    logic                  first;
    logic                  last;

    // Byte address of the word in this step
    glb_io_pkg::glb_addr_t addr;

    modport seq (
        output step,
        output write,
        output first,
        output last,
        output addr
    );

    modport bank (
        input  step,
        input  write,
        input  first,
        input  last,
        input  addr
    );

endinterface

`default_nettype wire

// File: src/glb_io_pkg.sv
// Global buffer I/O definitions
`default_nettype none

package glb_io_pkg;

    // Address and data widths
    localparam int GLB_ADDR_WIDTH  = 16;
    localparam int CGRA_DATA_WIDTH = 16;
    localparam int BANK_DATA_WIDTH = 64;

    // Fabric words packed into one bank word
    localparam int LANES          = 4;
    localparam int LANE_SEL_WIDTH = 2;

    // Byte step between consecutive fabric words
    localparam int CGRA_DATA_BYTES = 2;

    // Byte offset bits forced to zero on bank addresses
    localparam int BANK_ADDR_OFFSET = 3;

    localparam int DONE_DELAY_WIDTH = 8;

    // Cycles from bank read enable to bank data
    localparam int BANK_READ_LATENCY = 2;

    typedef logic [GLB_ADDR_WIDTH-1:0]   glb_addr_t;
    typedef logic [CGRA_DATA_WIDTH-1:0]  cgra_data_t;
    typedef logic [BANK_DATA_WIDTH-1:0]  bank_data_t;
    typedef logic [LANE_SEL_WIDTH-1:0]   lane_sel_t;
    typedef logic [DONE_DELAY_WIDTH-1:0] done_delay_t;

    // Stream direction selected by configuration
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        INSTREAM  = 2'd1,
        OUTSTREAM = 2'd2
    } stream_mode_t;

endpackage

`default_nettype wire
